// ==== tests/pitaya_stimulus.txt ====
// five hex words per record; op 1 write: addr wdata 0 err; op 2 read: addr 0 rdata err
// op 3 sample: adc_a adc_b dac_a dac_b; op 4 led: value 0 0 0; op 0 ends the list
2 00000000 0 00000001 0
4 00 0 0 0
3 1FFF 1FFF 1FFF 1FFF
1 00000030 000000A5 0 0
4 A5 0 0 0
2 00000030 0 000000A5 0
2 00000008 0 00000000 0
1 00000008 12345678 0 0
2 00000030 0 000000A5 0
2 00100000 0 00000000 1
1 00400000 0000DEAD 0 1
2 00500030 0 00000000 1
2 00600000 0 00000000 1
1 00700004 00000001 0 1
// dc levels with zero gain
1 00200000 00000100 0 0
1 00200004 FFFFFF00 0 0
2 00200004 0 FFFFFF00 0
3 1FFF 1FFF 1EFF 20FF
3 0000 3FFF 1EFF 20FF
// controller, a: sp 256 kp 256, b: sp -1024 kp -128
1 00200000 00000000 0 0
1 00200004 00000000 0 0
1 00300000 00000100 0 0
1 00300004 00000100 0 0
1 00300010 FFFFFC00 0 0
1 00300014 FFFFFF80 0 0
2 00300014 0 FFFFFF80 0
2 00300010 0 FFFFFC00 0
2 00300008 0 00000000 0
3 1FFF 1FFF 1EFF 1DFF
3 1EFF 2000 1FFF 1E00
3 0000 0000 3EFE 0E00
3 3FFF 3FFF 0000 2DFF
3 1000 2402 2EFE 2001
// levels near the rails
1 00200000 00001F00 0 0
1 00200004 FFFFE100 0 0
2 00200000 0 00001F00 0
3 1FFF 3FFF 0000 3FFF
3 1EFF 1FFF 00FF 3CFF
3 0000 0000 1FFE 2D00
0 0 0 0 0

// ==== tb.f ====
+incdir+include
logic/pitaya_pkg.sv
logic/sys_bus_if.sv
logic/sys_bus_decoder.sv
logic/hk_regs.sv
logic/adc_frontend.sv
logic/p_controller.sv
logic/dac_mixer.sv
logic/pitaya_top.sv
tests/tb_checker.sv
tests/tb_top.sv

// ==== Makefile ====
# Verilator build and run of the pitaya testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/tb_top.sv ====
//----------------------------------------------------------
// pitaya testbench
// clock, reset, file driven bus and adc stimulus, watchdog
//----------------------------------------------------------
`timescale 1ns/1ns
`include "pitaya_defines.svh"

module tb_top;

  localparam int REC_W    = 5;    // hex words per stimulus record
  localparam int MAX_REC  = 128;
  localparam int ACK_WAIT = 16;   // cycles allowed for an acknowledge

  logic                      adc_clk;
  logic                      reset_i;
  logic [`PITAYA_DATA_W-1:0] adc_dat_a;
  logic [`PITAYA_DATA_W-1:0] adc_dat_b;
  logic [`PITAYA_BUS_W-1:0]  sys_addr;
  logic [`PITAYA_BUS_W-1:0]  sys_wdata;
  logic                      sys_wen;
  logic                      sys_ren;
  logic [`PITAYA_BUS_W-1:0]  sys_rdata;
  logic                      sys_ack;
  logic                      sys_err;
  logic [7:0]                led;
  logic [`PITAYA_DATA_W-1:0] dac_a;
  logic [`PITAYA_DATA_W-1:0] dac_b;
  logic [`PITAYA_BUS_W-1:0]  exp_rdata;   // expected values for the checker
  logic                      exp_err;
  logic                      led_chk;
  logic [7:0]                exp_led;
  logic                      smp_chk;
  logic [`PITAYA_DATA_W-1:0] exp_dac_a;
  logic [`PITAYA_DATA_W-1:0] exp_dac_b;
  logic [`PITAYA_BUS_W-1:0]  stim_mem [REC_W*MAX_REC];
  logic                      stim_ready;
  int                        n_rec;
  int                        proto_errs;
  int                        check_cnt;
  int                        error_cnt;

  pitaya_top dut0 (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .adc_dat_a_i (adc_dat_a),
    .adc_dat_b_i (adc_dat_b),
    .sys_addr_i  (sys_addr),
    .sys_wdata_i (sys_wdata),
    .sys_wen_i   (sys_wen),
    .sys_ren_i   (sys_ren),
    .sys_rdata_o (sys_rdata),
    .sys_ack_o   (sys_ack),
    .sys_err_o   (sys_err),
    .led_o       (led),
    .dac_dat_a_o (dac_a),
    .dac_dat_b_o (dac_b)
  );

  tb_checker chk0 (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .sys_wen_i   (sys_wen),
    .sys_ren_i   (sys_ren),
    .sys_rdata_i (sys_rdata),
    .sys_ack_i   (sys_ack),
    .sys_err_i   (sys_err),
    .led_i       (led),
    .dac_a_i     (dac_a),
    .dac_b_i     (dac_b),
    .exp_rdata_i (exp_rdata),
    .exp_err_i   (exp_err),
    .led_chk_i   (led_chk),
    .exp_led_i   (exp_led),
    .smp_chk_i   (smp_chk),
    .exp_dac_a_i (exp_dac_a),
    .exp_dac_b_i (exp_dac_b),
    .check_cnt_o (check_cnt),
    .error_cnt_o (error_cnt)
  );

  initial begin
    adc_clk = 1'b0;
    forever #10 adc_clk = ~adc_clk;  // 20 ns period
  end

  // records run until the first op outside 1..4
  function automatic int count_records();
    int n;
    n = 0;
    while (n < MAX_REC && stim_mem[n*REC_W] >= 1 && stim_mem[n*REC_W] <= 4) begin
      n++;
    end
    return n;
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge adc_clk);
      #2;
    end
  endtask

  //----------------------------------------------------------
  // one bus access, enable for one cycle then wait for ack
  task automatic bus_access(input logic is_write, input logic [`PITAYA_BUS_W-1:0] addr,
                            input logic [`PITAYA_BUS_W-1:0] wdata,
                            input logic [`PITAYA_BUS_W-1:0] rdata, input logic err);
    int waited;
    sys_addr  = addr;
    sys_wdata = wdata;
    sys_wen   = is_write;
    sys_ren   = !is_write;
    exp_rdata = rdata;
    exp_err   = err;
    idle_cycles(1);
    sys_wen = 1'b0;
    sys_ren = 1'b0;
    waited  = 0;
    while (!sys_ack && waited < ACK_WAIT) begin
      idle_cycles(1);
      waited++;
    end
    if (!sys_ack) begin
      proto_errs++;
      $display("Bus access to %h got no acknowledge within %0d cycles", addr, ACK_WAIT);
    end
    idle_cycles(1);  // address held through the ack cycle
  endtask

  task automatic drive_sample(input logic [`PITAYA_DATA_W-1:0] a,
                              input logic [`PITAYA_DATA_W-1:0] b,
                              input logic [`PITAYA_DATA_W-1:0] exp_a,
                              input logic [`PITAYA_DATA_W-1:0] exp_b);
    adc_dat_a = a;
    adc_dat_b = b;
    exp_dac_a = exp_a;
    exp_dac_b = exp_b;
    smp_chk   = 1'b1;
    idle_cycles(1);
    smp_chk   = 1'b0;
  endtask

  task automatic check_led(input logic [7:0] value);
    exp_led = value;
    led_chk = 1'b1;
    idle_cycles(1);
    led_chk = 1'b0;
  endtask

  //----------------------------------------------------------
  // main sequence
  initial begin
    int   op;
    int   base;
    logic last_smp;
    int   total;
    reset_i    = 1'b1;
    adc_dat_a  = '0;
    adc_dat_b  = '0;
    sys_addr   = '0;
    sys_wdata  = '0;
    sys_wen    = 1'b0;
    sys_ren    = 1'b0;
    exp_rdata  = '0;
    exp_err    = 1'b0;
    led_chk    = 1'b0;
    exp_led    = '0;
    smp_chk    = 1'b0;
    exp_dac_a  = '0;
    exp_dac_b  = '0;
    proto_errs = 0;
    stim_ready = 1'b0;
    $readmemh("tests/pitaya_stimulus.txt", stim_mem);
    n_rec      = count_records();
    stim_ready = 1'b1;
    if (n_rec == 0) begin
      proto_errs++;
      $display("Stimulus file is missing or holds no records");
    end
    repeat (5) @(posedge adc_clk);
    #2;
    reset_i  = 1'b0;
    last_smp = 1'b0;
    for (int r = 0; r < n_rec; r++) begin
      base = r * REC_W;
      op   = stim_mem[base];
      if (last_smp && op != 3) begin
        idle_cycles(4);  // let samples in flight leave before regs change
      end
      case (op)
        1: bus_access(1'b1, stim_mem[base+1], stim_mem[base+2], '0, stim_mem[base+4][0]);
        2: bus_access(1'b0, stim_mem[base+1], '0, stim_mem[base+3], stim_mem[base+4][0]);
        3: drive_sample(stim_mem[base+1][`PITAYA_DATA_W-1:0], stim_mem[base+2][`PITAYA_DATA_W-1:0],
                        stim_mem[base+3][`PITAYA_DATA_W-1:0], stim_mem[base+4][`PITAYA_DATA_W-1:0]);
        default: check_led(stim_mem[base+1][7:0]);
      endcase
      last_smp = (op == 3);
    end
    idle_cycles(8);  // last dac compare
    total = error_cnt + proto_errs;
    $display("checks %0d, errors %0d (compare %0d, protocol %0d)",
             check_cnt, total, error_cnt, proto_errs);
    if (total == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // watchdog, 20 cycles per record plus margin
  initial begin
    int limit;
    wait (stim_ready);
    limit = n_rec * 20 + 100;
    repeat (limit) @(posedge adc_clk);
    $display("Watchdog expired, run still busy after %0d cycles", limit);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// ==== tests/tb_checker.sv ====
//----------------------------------------------------------
// testbench checker
// watches bus replies, led and dac outputs of the DUT and
// compares them against expected values from tb_top
//----------------------------------------------------------
`timescale 1ns/1ns
`include "pitaya_defines.svh"

module tb_checker (
  input  logic                      adc_clk,
  input  logic                      reset_i,
  input  logic                      sys_wen_i,     // DUT bus inputs
  input  logic                      sys_ren_i,
  input  logic [`PITAYA_BUS_W-1:0]  sys_rdata_i,   // DUT bus outputs
  input  logic                      sys_ack_i,
  input  logic                      sys_err_i,
  input  logic [7:0]                led_i,
  input  logic [`PITAYA_DATA_W-1:0] dac_a_i,
  input  logic [`PITAYA_DATA_W-1:0] dac_b_i,
  input  logic [`PITAYA_BUS_W-1:0]  exp_rdata_i,   // held with the request
  input  logic                      exp_err_i,
  input  logic                      led_chk_i,     // one cycle strobe
  input  logic [7:0]                exp_led_i,
  input  logic                      smp_chk_i,     // one cycle per sample
  input  logic [`PITAYA_DATA_W-1:0] exp_dac_a_i,
  input  logic [`PITAYA_DATA_W-1:0] exp_dac_b_i,
  output int                        check_cnt_o,
  output int                        error_cnt_o
);

  localparam int LAT = 4;  // adc in to dac out, cycles

  int                        checks = 0;
  int                        errors = 0;
  logic                      prev_req;      // request seen one cycle ago
  logic                      req_read;
  logic [`PITAYA_BUS_W-1:0]  req_rdata;
  logic                      req_err;
  logic [LAT-1:0]            dac_vld;       // expected dac delay line
  logic [`PITAYA_DATA_W-1:0] exp_a_q [LAT];
  logic [`PITAYA_DATA_W-1:0] exp_b_q [LAT];

  assign check_cnt_o = checks;
  assign error_cnt_o = errors;

  task automatic compare_val(input string name, input logic [`PITAYA_BUS_W-1:0] got,
                             input logic [`PITAYA_BUS_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  //----------------------------------------------------------
  // sampled mid cycle, all DUT outputs settled
  always @(negedge adc_clk) begin
    if (reset_i) begin
      prev_req = 1'b0;
      dac_vld  = '0;
    end else begin
      if (sys_ack_i) begin
        if (!prev_req) begin
          errors++;
          $display("Protocol error at %0t ns: acknowledge without a request one cycle earlier",
                   $time);
        end else begin
          compare_val("sys_err_o", 32'(sys_err_i), 32'(req_err));
          if (req_read) begin
            compare_val("sys_rdata_o", sys_rdata_i, req_rdata);
          end
        end
      end else if (sys_err_i) begin
        errors++;
        $display("Protocol error at %0t ns: error flag raised without an acknowledge", $time);
      end
      if (sys_wen_i || sys_ren_i) begin  // latch what the reply must be
        req_read  = sys_ren_i;
        req_rdata = exp_rdata_i;
        req_err   = exp_err_i;
      end
      prev_req = sys_wen_i || sys_ren_i;

      if (led_chk_i) begin
        compare_val("led_o", 32'(led_i), 32'(exp_led_i));
      end

      // oldest sample leaves the delay line now
      if (dac_vld[LAT-1]) begin
        compare_val("dac_dat_a_o", 32'(dac_a_i), 32'(exp_a_q[LAT-1]));
        compare_val("dac_dat_b_o", 32'(dac_b_i), 32'(exp_b_q[LAT-1]));
      end
      for (int i = LAT - 1; i > 0; i--) begin
        dac_vld[i] = dac_vld[i-1];
        exp_a_q[i] = exp_a_q[i-1];
        exp_b_q[i] = exp_b_q[i-1];
      end
      dac_vld[0] = smp_chk_i;
      exp_a_q[0] = exp_dac_a_i;
      exp_b_q[0] = exp_dac_b_i;
    end
  end

endmodule

// ==== logic/pitaya_top.sv ====
//----------------------------------------------------------
// pitaya top level
// adc -> controller -> dc mixer -> dac, with the register bus
//----------------------------------------------------------
`timescale 1ns/1ns
`include "pitaya_defines.svh"

module pitaya_top (
  input  logic                      adc_clk,
  input  logic                      reset_i,
  input  logic [`PITAYA_DATA_W-1:0] adc_dat_a_i,
  input  logic [`PITAYA_DATA_W-1:0] adc_dat_b_i,
  input  logic [`PITAYA_BUS_W-1:0]  sys_addr_i,
  input  logic [`PITAYA_BUS_W-1:0]  sys_wdata_i,
  input  logic                      sys_wen_i,
  input  logic                      sys_ren_i,
  output logic [`PITAYA_BUS_W-1:0]  sys_rdata_o,
  output logic                      sys_ack_o,
  output logic                      sys_err_o,
  output logic [7:0]                led_o,
  output logic [`PITAYA_DATA_W-1:0] dac_dat_a_o,
  output logic [`PITAYA_DATA_W-1:0] dac_dat_b_o
);
  import pitaya_pkg::*;

  sample_t adc_a;  // converted adc
  sample_t adc_b;
  sample_t pid_a;  // controller out
  sample_t pid_b;

  sys_bus_if hk_bus ();   // region 0
  sys_bus_if dc_bus ();   // region 2
  sys_bus_if pid_bus ();  // region 3

  //----------------------------------------------------------
  // register bus
  sys_bus_decoder i_decoder (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o),
    .hk_bus      (hk_bus.master),
    .dc_bus      (dc_bus.master),
    .pid_bus     (pid_bus.master)
  );

  hk_regs i_hk (
    .adc_clk (adc_clk),
    .reset_i (reset_i),
    .bus     (hk_bus.slave),
    .led_o   (led_o)
  );

  //----------------------------------------------------------
  // signal path, four cycles adc to dac
  adc_frontend i_adc (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .adc_a_o     (adc_a),
    .adc_b_o     (adc_b)
  );

  p_controller i_pid (
    .adc_clk (adc_clk),
    .reset_i (reset_i),
    .bus     (pid_bus.slave),
    .adc_a_i (adc_a),
    .adc_b_i (adc_b),
    .pid_a_o (pid_a),
    .pid_b_o (pid_b)
  );

  dac_mixer i_mixer (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .bus         (dc_bus.slave),
    .pid_a_i     (pid_a),
    .pid_b_i     (pid_b),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o)
  );

endmodule

// ==== logic/dac_mixer.sv ====
//----------------------------------------------------------
// dac mixer
// dc level per channel plus controller output, saturated
// and registered as dac code
//----------------------------------------------------------
`timescale 1ns/1ns
`include "pitaya_defines.svh"

module dac_mixer (
  input  logic                      adc_clk,
  input  logic                      reset_i,
  sys_bus_if.slave                  bus,
  input  pitaya_pkg::sample_t       pid_a_i,
  input  pitaya_pkg::sample_t       pid_b_i,
  output logic [`PITAYA_DATA_W-1:0] dac_dat_a_o,  // offset code
  output logic [`PITAYA_DATA_W-1:0] dac_dat_b_o
);
  import pitaya_pkg::*;

  sample_t                   dc_q  [2];  // dc levels
  sample_t                   pid_w [2];
  logic [`PITAYA_DATA_W-1:0] dac_q [2];
  logic [`PITAYA_BUS_W-1:0]  rdata_d;
  logic [`PITAYA_BUS_W-1:0]  rdata_q;
  logic                      ack_q;

  assign pid_w[0] = pid_a_i;
  assign pid_w[1] = pid_b_i;

  //----------------------------------------------------------
  // register access
  always_comb begin
    case (bus.addr.dec.offset)
      `PITAYA_DC_A: rdata_d = `PITAYA_BUS_W'(dc_q[0]);  // sign extended
      `PITAYA_DC_B: rdata_d = `PITAYA_BUS_W'(dc_q[1]);
      default:      rdata_d = '0;
    endcase
  end

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      dc_q[0] <= '0;
      dc_q[1] <= '0;
      ack_q   <= 1'b0;
    end else begin
      ack_q <= bus.wen | bus.ren;
      if (bus.wen && bus.addr.dec.offset == `PITAYA_DC_A) begin
        dc_q[0] <= bus.wdata[`PITAYA_DATA_W-1:0];
      end
      if (bus.wen && bus.addr.dec.offset == `PITAYA_DC_B) begin
        dc_q[1] <= bus.wdata[`PITAYA_DATA_W-1:0];
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (bus.ren) begin
      rdata_q <= rdata_d;
    end
  end

  assign bus.rdata = rdata_q;
  assign bus.ack   = ack_q;
  assign bus.err   = 1'b0;

  //----------------------------------------------------------
  // sum, saturate, convert
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      for (int i = 0; i < 2; i++) begin
        dac_q[i] <= code_flip('0);  // code for zero
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        dac_q[i] <= code_flip(sat_sample(`PITAYA_BUS_W'(dc_q[i])
                                         + `PITAYA_BUS_W'(pid_w[i])));
      end
    end
  end

  assign dac_dat_a_o = dac_q[0];
  assign dac_dat_b_o = dac_q[1];

  // whole upstream path must be defined once out of reset
  dac_known: assert property (@(posedge adc_clk) disable iff (reset_i)
    !$isunknown({dac_dat_a_o, dac_dat_b_o}));

endmodule

// ==== logic/p_controller.sv ====
//----------------------------------------------------------
// proportional controller
// per channel setpoint and gain, error stage, then scaled
// and saturated output stage
//----------------------------------------------------------
`timescale 1ns/1ns
`include "pitaya_defines.svh"

module p_controller (
  input  logic                adc_clk,
  input  logic                reset_i,
  sys_bus_if.slave            bus,
  input  pitaya_pkg::sample_t adc_a_i,
  input  pitaya_pkg::sample_t adc_b_i,
  output pitaya_pkg::sample_t pid_a_o,
  output pitaya_pkg::sample_t pid_b_o
);
  import pitaya_pkg::*;

  localparam int ERR_W  = `PITAYA_DATA_W + 1;   // difference needs one more bit
  localparam int PROD_W = ERR_W + `PITAYA_KP_W;

  sample_t                        sp_q     [2];  // setpoints
  logic signed [`PITAYA_KP_W-1:0] kp_q     [2];  // gains
  sample_t                        adc_w    [2];
  logic signed [ERR_W-1:0]        err_q    [2];  // stage 1
  logic signed [PROD_W-1:0]       prod_w   [2];
  logic signed [PROD_W-1:0]       scaled_w [2];  // after shift
  sample_t                        pid_q    [2];  // stage 2
  logic [`PITAYA_BUS_W-1:0]       rdata_d;
  logic [`PITAYA_BUS_W-1:0]       rdata_q;
  logic                           ack_q;

  assign adc_w[0] = adc_a_i;
  assign adc_w[1] = adc_b_i;

  //----------------------------------------------------------
  // register access
  always_comb begin
    case (bus.addr.dec.offset)
      `PITAYA_PID_SP_A: rdata_d = `PITAYA_BUS_W'(sp_q[0]);  // sign extended
      `PITAYA_PID_KP_A: rdata_d = `PITAYA_BUS_W'(kp_q[0]);
      `PITAYA_PID_SP_B: rdata_d = `PITAYA_BUS_W'(sp_q[1]);
      `PITAYA_PID_KP_B: rdata_d = `PITAYA_BUS_W'(kp_q[1]);
      default:          rdata_d = '0;
    endcase
  end

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      for (int i = 0; i < 2; i++) begin
        sp_q[i] <= '0;
        kp_q[i] <= '0;  // zero gain, output idles at 0
      end
      ack_q <= 1'b0;
    end else begin
      ack_q <= bus.wen | bus.ren;
      if (bus.wen) begin
        case (bus.addr.dec.offset)
          `PITAYA_PID_SP_A: sp_q[0] <= bus.wdata[`PITAYA_DATA_W-1:0];
          `PITAYA_PID_KP_A: kp_q[0] <= bus.wdata[`PITAYA_KP_W-1:0];
          `PITAYA_PID_SP_B: sp_q[1] <= bus.wdata[`PITAYA_DATA_W-1:0];
          `PITAYA_PID_KP_B: kp_q[1] <= bus.wdata[`PITAYA_KP_W-1:0];
          default: ;  // unknown offset, write dropped
        endcase
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (bus.ren) begin
      rdata_q <= rdata_d;
    end
  end

  assign bus.rdata = rdata_q;
  assign bus.ack   = ack_q;
  assign bus.err   = 1'b0;

  //----------------------------------------------------------
  // data path, two cycles
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      prod_w[i]   = err_q[i] * kp_q[i];                // full precision
      scaled_w[i] = prod_w[i] >>> `PITAYA_KP_SHIFT;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      for (int i = 0; i < 2; i++) begin
        err_q[i] <= '0;
        pid_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        err_q[i] <= ERR_W'(sp_q[i]) - ERR_W'(adc_w[i]);
        pid_q[i] <= sat_sample(`PITAYA_BUS_W'(scaled_w[i]));
      end
    end
  end

  assign pid_a_o = pid_q[0];
  assign pid_b_o = pid_q[1];

  // correction never points against the sign of error times gain
  for (genvar g = 0; g < 2; g++) begin : g_sign_chk
    out_sign_neg: assert property (@(posedge adc_clk) disable iff (reset_i)
      ((err_q[g] < 0) != (kp_q[g] < 0)) |=> (pid_q[g] <= 0));
    out_sign_pos: assert property (@(posedge adc_clk) disable iff (reset_i)
      ((err_q[g] < 0) == (kp_q[g] < 0)) |=> (pid_q[g] >= 0));
  end

endmodule

// ==== logic/adc_frontend.sv ====
//----------------------------------------------------------
// adc front end
// registers both channels, offset code to two's complement
//----------------------------------------------------------
`timescale 1ns/1ns
`include "pitaya_defines.svh"

module adc_frontend (
  input  logic                      adc_clk,
  input  logic                      reset_i,
  input  logic [`PITAYA_DATA_W-1:0] adc_dat_a_i,  // negative slope code
  input  logic [`PITAYA_DATA_W-1:0] adc_dat_b_i,
  output pitaya_pkg::sample_t       adc_a_o,
  output pitaya_pkg::sample_t       adc_b_o
);
  import pitaya_pkg::*;

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      adc_a_o <= '0;
      adc_b_o <= '0;
    end else begin
      adc_a_o <= code_flip(adc_dat_a_i);  // one cycle latency
      adc_b_o <= code_flip(adc_dat_b_i);
    end
  end

endmodule

// ==== logic/hk_regs.sv ====
//----------------------------------------------------------
// housekeeping registers
// read-only id word and the led register
//----------------------------------------------------------
`timescale 1ns/1ns
`include "pitaya_defines.svh"

module hk_regs (
  input  logic       adc_clk,
  input  logic       reset_i,
  sys_bus_if.slave   bus,
  output logic [7:0] led_o
);

  logic [`PITAYA_BUS_W-1:0] rdata_d;  // read mux
  logic [`PITAYA_BUS_W-1:0] rdata_q;
  logic                     ack_q;

  always_comb begin
    case (bus.addr.dec.offset)
      `PITAYA_HK_ID:  rdata_d = `PITAYA_ID_WORD;
      `PITAYA_HK_LED: rdata_d = {{(`PITAYA_BUS_W-8){1'b0}}, led_o};
      default:        rdata_d = '0;  // unknown offset reads zero
    endcase
  end

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      led_o <= '0;
      ack_q <= 1'b0;
    end else begin
      ack_q <= bus.wen | bus.ren;  // every access acked
      if (bus.wen && bus.addr.dec.offset == `PITAYA_HK_LED) begin
        led_o <= bus.wdata[7:0];
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (bus.ren) begin
      rdata_q <= rdata_d;
    end
  end

  assign bus.rdata = rdata_q;
  assign bus.ack   = ack_q;
  assign bus.err   = 1'b0;  // mapped region never errors

endmodule

// ==== logic/sys_bus_decoder.sv ====
//----------------------------------------------------------
// system bus decoder
// splits the bus into regions on addr[22:20], muxes replies
// and answers unmapped regions with an error acknowledge
//----------------------------------------------------------
`timescale 1ns/1ns
`include "pitaya_defines.svh"

module sys_bus_decoder (
  input  logic                     adc_clk,
  input  logic                     reset_i,
  input  pitaya_pkg::sys_addr_u    sys_addr_i,
  input  logic [`PITAYA_BUS_W-1:0] sys_wdata_i,
  input  logic                     sys_wen_i,
  input  logic                     sys_ren_i,
  output logic [`PITAYA_BUS_W-1:0] sys_rdata_o,
  output logic                     sys_ack_o,
  output logic                     sys_err_o,
  sys_bus_if.master                hk_bus,
  sys_bus_if.master                dc_bus,
  sys_bus_if.master                pid_bus
);

  logic [`PITAYA_REGIONS-1:0] region_cs;    // one-hot region select
  logic                       mapped;       // region has a peripheral
  logic                       unmap_ack_q;  // error answer, one cycle

  assign region_cs = `PITAYA_REGIONS'(1) << sys_addr_i.dec.region;
  assign mapped    = region_cs[`PITAYA_REG_HK] | region_cs[`PITAYA_REG_DC]
                   | region_cs[`PITAYA_REG_PID];

  //----------------------------------------------------------
  // request side
  assign hk_bus.addr.word  = sys_addr_i.word;
  assign hk_bus.wdata      = sys_wdata_i;
  assign hk_bus.wen        = sys_wen_i & region_cs[`PITAYA_REG_HK];
  assign hk_bus.ren        = sys_ren_i & region_cs[`PITAYA_REG_HK];

  assign dc_bus.addr.word  = sys_addr_i.word;
  assign dc_bus.wdata      = sys_wdata_i;
  assign dc_bus.wen        = sys_wen_i & region_cs[`PITAYA_REG_DC];
  assign dc_bus.ren        = sys_ren_i & region_cs[`PITAYA_REG_DC];

  assign pid_bus.addr.word = sys_addr_i.word;
  assign pid_bus.wdata     = sys_wdata_i;
  assign pid_bus.wen       = sys_wen_i & region_cs[`PITAYA_REG_PID];
  assign pid_bus.ren       = sys_ren_i & region_cs[`PITAYA_REG_PID];

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      unmap_ack_q <= 1'b0;
    end else begin
      unmap_ack_q <= (sys_wen_i | sys_ren_i) & ~mapped;  // regions 1, 4..7
    end
  end

  //----------------------------------------------------------
  // reply side, address held until ack so region still valid
  always_comb begin
    sys_rdata_o = '0;           // unmapped reads give zero
    sys_ack_o   = unmap_ack_q;
    sys_err_o   = unmap_ack_q;
    case (sys_addr_i.dec.region)
      `PITAYA_REG_HK: begin
        sys_rdata_o = hk_bus.rdata;
        sys_ack_o   = hk_bus.ack;
        sys_err_o   = hk_bus.err;
      end
      `PITAYA_REG_DC: begin
        sys_rdata_o = dc_bus.rdata;
        sys_ack_o   = dc_bus.ack;
        sys_err_o   = dc_bus.err;
      end
      `PITAYA_REG_PID: begin
        sys_rdata_o = pid_bus.rdata;
        sys_ack_o   = pid_bus.ack;
        sys_err_o   = pid_bus.err;
      end
      default: ;
    endcase
  end

  // every reply, mapped or not, answers a strobe one cycle earlier
  ack_after_strobe: assert property (@(posedge adc_clk) disable iff (reset_i)
    sys_ack_o |-> $past(sys_wen_i | sys_ren_i));

endmodule

// ==== logic/sys_bus_if.sv ====
//----------------------------------------------------------
// system bus region
// one decoded region between decoder and peripheral
//----------------------------------------------------------
`timescale 1ns/1ns
`include "pitaya_defines.svh"

interface sys_bus_if;
  import pitaya_pkg::*;

  sys_addr_u                addr;   // full address, offset read by slave
  logic [`PITAYA_BUS_W-1:0] wdata;  // full word writes only
  logic                     wen;    // single cycle write strobe
  logic                     ren;    // single cycle read strobe
  logic [`PITAYA_BUS_W-1:0] rdata;  // valid with ack
  logic                     ack;    // one cycle after strobe
  logic                     err;

  modport master (
    output addr, wdata, wen, ren,
    input  rdata, ack, err
  );

  modport slave (
    input  addr, wdata, wen, ren,
    output rdata, ack, err
  );

endinterface

// ==== logic/pitaya_pkg.sv ====
//----------------------------------------------------------
// pitaya types
// signed samples, bus address view and sample helpers
//----------------------------------------------------------
`include "pitaya_defines.svh"

package pitaya_pkg;

  typedef logic signed [`PITAYA_DATA_W-1:0] sample_t;  // two's complement sample

  typedef struct packed {
    logic [`PITAYA_BUS_W-24:0] upper;   // bits 31:23, unused
    logic [2:0]                region;  // bits 22:20
    logic [19:0]               offset;  // register offset in region
  } sys_addr_t;

  typedef union packed {
    logic [`PITAYA_BUS_W-1:0] word;  // flat bus address
    sys_addr_t                dec;   // region and offset view
  } sys_addr_u;

  localparam int SAMPLE_MAX = 2 ** (`PITAYA_DATA_W - 1) - 1;  // 0x1fff
  localparam int SAMPLE_MIN = -(2 ** (`PITAYA_DATA_W - 1));   // 0x2000

  // clamp a wide signed value into the sample range
  function automatic sample_t sat_sample(input logic signed [`PITAYA_BUS_W-1:0] v);
    if (v > SAMPLE_MAX) return sample_t'(SAMPLE_MAX);
    else if (v < SAMPLE_MIN) return sample_t'(SAMPLE_MIN);
    else return sample_t'(v);
  endfunction

  // negative slope offset code <-> two's complement, self inverse
  function automatic logic [`PITAYA_DATA_W-1:0] code_flip(
    input logic [`PITAYA_DATA_W-1:0] c
  );
    return {c[`PITAYA_DATA_W-1], ~c[`PITAYA_DATA_W-2:0]};  // keep msb, invert rest
  endfunction

endpackage

// ==== include/pitaya_defines.svh ====
//----------------------------------------------------------
// pitaya parameters
// sample and bus widths, region map, register offsets,
// identification word and controller scaling
//----------------------------------------------------------
`ifndef PITAYA_DEFINES_SVH
`define PITAYA_DEFINES_SVH

`define PITAYA_DATA_W     14             // adc and dac sample width
`define PITAYA_BUS_W      32             // bus address and data width
`define PITAYA_REGIONS    8              // regions on addr[22:20]

// region numbers
`define PITAYA_REG_HK     3'd0           // housekeeping
`define PITAYA_REG_DC     3'd2           // dc levels
`define PITAYA_REG_PID    3'd3           // controller

// housekeeping offsets
`define PITAYA_HK_ID      20'h00000
`define PITAYA_HK_LED     20'h00030

// dc level offsets
`define PITAYA_DC_A       20'h00000
`define PITAYA_DC_B       20'h00004

// controller offsets
`define PITAYA_PID_SP_A   20'h00000
`define PITAYA_PID_KP_A   20'h00004
`define PITAYA_PID_SP_B   20'h00010
`define PITAYA_PID_KP_B   20'h00014

`define PITAYA_ID_WORD    32'h0000_0001  // board id
`define PITAYA_KP_W       12             // signed gain width
`define PITAYA_KP_SHIFT   8              // product scaling, arithmetic

`endif
